// File: hdl/msx_params.svh
`ifndef MSX_PARAMS_SVH
`define MSX_PARAMS_SVH

// I/O ports
`define PPI_PORT        8'ha8
`define CFG_PORT_KEY    8'h40
`define CFG_PORT_MAIN   8'h41
`define CFG_PORT_AUX    8'h42
`define CFG_READ_NIBBLE 4'h4
`define MAPPER_PORT_HI  6'b111111

// configuration unlock and reset values
`define CFG_KEY         8'hb7
`define CFG_MAIN_RESET  8'h0b

// mapper RAM holds 2**MAPPER_SEG_BITS pages of 16 KB
`define MAPPER_SEG_BITS 3

// value seen on an undriven data bus
`define OPEN_BUS        8'hff

`endif

// File: hdl/msx_pkg.sv
package msx_pkg;

    //------------------------------------------------------------
    // cpu bus address, one word seen two ways
    //------------------------------------------------------------
    typedef struct packed {
        logic [1:0]  page;
        logic [13:0] offset;
    } mem_addr_t;

    typedef struct packed {
        logic [7:0] unused;
        logic [7:0] port;
    } io_addr_t;

    typedef union packed {
        mem_addr_t mem;
        io_addr_t  io;
    } bus_addr_u;

    // one bus cycle, valid for a single clock
    typedef struct packed {
        logic       valid;
        logic       io;
        logic       write;
        bus_addr_u  addr;
        logic [7:0] wdata;
    } bus_req_t;

    //------------------------------------------------------------
    // decode results and read claims
    //------------------------------------------------------------
    typedef struct packed {
        logic [1:0] pri_slot;
        logic [1:0] sub_slot;
        logic       xffff;
    } slot_sel_t;

    typedef struct packed {
        logic       mapper_en;
        logic [1:0] mapper_slot;
    } cfg_t;

    typedef struct packed {
        logic       hit;
        logic [7:0] data;
    } src_rd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rd_rsp_t;

endpackage

// File: hdl/mapper_ram.sv
`timescale 1ns/1ps

`include "msx_params.svh"

module mapper_ram (
    input  logic                          clk_108m,
    input  logic                          we,
    input  logic [`MAPPER_SEG_BITS+13:0]  addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata
);

    localparam int DEPTH = 2 ** (`MAPPER_SEG_BITS + 14);

    logic [7:0] mem [DEPTH];

    // read data lands one cycle after the address
    always_ff @(posedge clk_108m) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: hdl/slot_select.sv
`timescale 1ns/1ps

`include "msx_params.svh"

module slot_select import msx_pkg::*; (
    input  logic      clk_108m,
    input  logic      bus_reset_n,
    input  bus_req_t  req,
    output slot_sel_t sel,
    output src_rd_t   exp_rd
);

    // 2 bits per page, page 0 in the low bits
    logic [7:0] ppi_port_a;
    logic [7:0] exp_slot0;

    logic [1:0] page;
    logic       xffff;
    logic       page3_in_slot0;
    logic       ppi_wr;
    logic       exp_wr;

    assign page  = req.addr.mem.page;
    assign xffff = (req.addr == 16'hffff);

    // sub-slot register is only visible while page 3 sits in slot 0
    assign page3_in_slot0 = (ppi_port_a[7:6] == 2'b00);

    assign ppi_wr = req.valid && req.write && req.io
                 && (req.addr.io.port == `PPI_PORT);
    assign exp_wr = req.valid && req.write && !req.io
                 && xffff && page3_in_slot0;

    //------------------------------------------------------------
    // slot registers
    //------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            ppi_port_a <= 8'h00;
            exp_slot0  <= 8'h00;
        end else begin
            if (ppi_wr) begin
                ppi_port_a <= req.wdata;
            end
            if (exp_wr) begin
                exp_slot0 <= req.wdata;
            end
        end
    end

    // per-access decode of the addressed page
    always_comb begin
        sel.pri_slot = ppi_port_a[page*2 +: 2];
        sel.sub_slot = exp_slot0[page*2 +: 2];
        sel.xffff    = xffff;
    end

    // FFFFh reads back inverted
    always_comb begin
        exp_rd.hit  = !req.io && xffff && page3_in_slot0;
        exp_rd.data = ~exp_slot0;
    end

endmodule

// File: hdl/config_regs.sv
`timescale 1ns/1ps

`include "msx_params.svh"

module config_regs import msx_pkg::*; (
    input  logic     clk_108m,
    input  logic     bus_reset_n,
    input  bus_req_t req,
    output cfg_t     cfg,
    output src_rd_t  cfg_rd
);

    logic [7:0] key_reg;
    logic [7:0] main_reg;

    logic [7:0] port;
    logic       io_wr;
    logic       unlocked;

    assign port     = req.addr.io.port;
    assign io_wr    = req.valid && req.write && req.io;
    assign unlocked = (key_reg == `CFG_KEY);

    //------------------------------------------------------------
    // key and configuration registers
    //------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            key_reg  <= 8'h00;
            main_reg <= `CFG_MAIN_RESET;
        end else if (io_wr) begin
            // key is stored inverted, so 48h opens the lock
            if (port == `CFG_PORT_KEY) begin
                key_reg <= ~req.wdata;
            end
            if (unlocked && port == `CFG_PORT_MAIN) begin
                main_reg <= req.wdata;
            end
        end
    end

    // fields act right away
    always_comb begin
        cfg.mapper_en   = main_reg[0];
        cfg.mapper_slot = main_reg[5:4];
    end

    // read-back over 40h..4Fh
    always_comb begin
        cfg_rd.hit = req.io && (port[7:4] == `CFG_READ_NIBBLE);
        case (port[3:0])
            4'h0:    cfg_rd.data = key_reg;
            4'h1:    cfg_rd.data = main_reg;
            default: cfg_rd.data = `OPEN_BUS;
        endcase
    end

endmodule

// File: hdl/mapper_ctrl.sv
`timescale 1ns/1ps

`include "msx_params.svh"

module mapper_ctrl import msx_pkg::*; (
    input  logic       clk_108m,
    input  logic       bus_reset_n,
    input  bus_req_t   req,
    input  slot_sel_t  sel,
    input  cfg_t       cfg,
    output logic       map_hit,
    output logic [7:0] map_data
);

    localparam int SEG_W = `MAPPER_SEG_BITS;

    // only the bits that reach the RAM are kept
    logic [SEG_W-1:0]    seg [4];
    logic [SEG_W+13:0]   phys_addr;
    logic                seg_wr;
    logic                slot_match;
    logic                sub_ok;
    logic                ram_we;

    assign seg_wr = req.valid && req.write && req.io
                 && (req.addr.io.port[7:2] == `MAPPER_PORT_HI);

    //------------------------------------------------------------
    // segment registers, FCh..FFh
    //------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            seg[0] <= SEG_W'(3);
            seg[1] <= SEG_W'(2);
            seg[2] <= SEG_W'(1);
            seg[3] <= SEG_W'(0);
        end else if (seg_wr) begin
            seg[req.addr.io.port[1:0]] <= req.wdata[SEG_W-1:0];
        end
    end

    // hit decode
    assign slot_match = (sel.pri_slot == cfg.mapper_slot);

    // in slot 0 the mapper lives in sub-slot 3, minus the FFFFh register
    assign sub_ok = (sel.pri_slot != 2'b00)
                 || ((sel.sub_slot == 2'b11) && !sel.xffff);

    assign map_hit = !req.io && cfg.mapper_en && slot_match && sub_ok;

    assign phys_addr = {seg[req.addr.mem.page], req.addr.mem.offset};
    assign ram_we    = req.valid && req.write && map_hit;

    mapper_ram u_ram (
        .clk_108m (clk_108m),
        .we       (ram_we),
        .addr     (phys_addr),
        .wdata    (req.wdata),
        .rdata    (map_data)
    );

endmodule

// File: hdl/read_mux.sv
`timescale 1ns/1ps

`include "msx_params.svh"

module read_mux import msx_pkg::*; (
    input  logic       clk_108m,
    input  logic       bus_reset_n,
    input  bus_req_t   req,
    input  logic       map_hit,
    input  logic [7:0] map_data,
    input  src_rd_t    exp_rd,
    input  src_rd_t    cfg_rd,
    output rd_rsp_t    rsp
);

    logic       rd_strobe;
    logic       rsp_valid_q;
    logic       map_won_q;
    logic [7:0] data_q;
    logic [7:0] data_d;

    assign rd_strobe = req.valid && !req.write;

    // priority below the mapper
    always_comb begin
        if (exp_rd.hit) begin
            data_d = exp_rd.data;
        end else if (cfg_rd.hit) begin
            data_d = cfg_rd.data;
        end else begin
            data_d = `OPEN_BUS;
        end
    end

    //------------------------------------------------------------
    // response stage
    //------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            rsp_valid_q <= 1'b0;
            map_won_q   <= 1'b0;
        end else begin
            rsp_valid_q <= rd_strobe;
            if (rd_strobe) begin
                map_won_q <= map_hit;
            end
        end
    end

    always_ff @(posedge clk_108m) begin
        if (rd_strobe) begin
            data_q <= data_d;
        end
    end

    // RAM output already registered, so it is taken as it arrives
    always_comb begin
        rsp.valid = rsp_valid_q;
        rsp.data  = map_won_q ? map_data : data_q;
    end

endmodule

// File: hdl/msx_slot_top.sv
`timescale 1ns/1ps

module msx_slot_top import msx_pkg::*; (
    input  logic     clk_108m,
    input  logic     bus_reset_n,
    input  bus_req_t req,
    output rd_rsp_t  rsp
);

    slot_sel_t  sel;
    src_rd_t    exp_rd;
    cfg_t       cfg;
    src_rd_t    cfg_rd;
    logic       map_hit;
    logic [7:0] map_data;

    //------------------------------------------------------------
    // slot and configuration decode
    //------------------------------------------------------------
    slot_select u_slot_select (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .req         (req),
        .sel         (sel),
        .exp_rd      (exp_rd)
    );

    config_regs u_config_regs (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .req         (req),
        .cfg         (cfg),
        .cfg_rd      (cfg_rd)
    );

    // memory mapper with its RAM
    mapper_ctrl u_mapper_ctrl (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .req         (req),
        .sel         (sel),
        .cfg         (cfg),
        .map_hit     (map_hit),
        .map_data    (map_data)
    );

    read_mux u_read_mux (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .req         (req),
        .map_hit     (map_hit),
        .map_data    (map_data),
        .exp_rd      (exp_rd),
        .cfg_rd      (cfg_rd),
        .rsp         (rsp)
    );

endmodule

// File: tests/msx_slot_assert.sv
`timescale 1ns/1ps

module msx_slot_assert import msx_pkg::*; (
    input logic     clk_108m,
    input logic     bus_reset_n,
    input bus_req_t req,
    input rd_rsp_t  rsp
);

    // failures seen so far
    int fail_count = 0;

    logic rd_strobe;

    assign rd_strobe = req.valid && !req.write;

    //------------------------------------------------------------
    // response timing
    //------------------------------------------------------------
    rsp_quiet_in_reset: assert property (@(posedge clk_108m) !bus_reset_n |-> !rsp.valid)
    else begin
        $error("rsp.valid high while bus_reset_n is low");
        fail_count++;
    end

    // exactly one response, one cycle after each read strobe
    rsp_follows_read: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        rsp.valid == $past(rd_strobe))
    else begin
        $error("rsp.valid does not follow the read strobe of the previous cycle");
        fail_count++;
    end

    rsp_data_known: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        rsp.valid |-> !$isunknown(rsp.data))
    else begin
        $error("rsp.data holds X or Z while rsp.valid is high");
        fail_count++;
    end

endmodule

// File: tests/tb_msx_slot.sv
`timescale 1ns/1ps

`include "msx_params.svh"

module tb_msx_slot import msx_pkg::*; ();

    localparam int N_SLOT = 30;
    localparam int N_MAP  = 60;
    localparam int N_MIX  = 200;
    // bus transactions over all tests, a mapper read may add one write
    localparam int N_TXN      = 10 + N_SLOT * 12 + 4 * (6 + N_MAP * 2)
                              + 2 + N_MIX / 20 * 3 + N_MIX * 2;
    localparam int TIMEOUT_NS = N_TXN * 4 * 20 * 2;

    typedef struct packed {
        logic [31:0] cyc;
        logic        check;
        logic [15:0] addr;
        logic [7:0]  data;
    } rsp_exp_t;

    logic        clk_108m;
    logic        bus_reset_n;
    bus_req_t    req;
    rd_rsp_t     rsp;
    rsp_exp_t    exp_q[$];
    rsp_exp_t    head;
    logic [31:0] cyc = '0;
    logic [31:0] lcg_state = 32'd61231;
    string       test_name = "none";
    int          err_count = 0;
    int          test_errs_base = 0;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_reads = 0;
    int          n_rsp = 0;

    // reference model, RAM holds written bytes only
    logic [7:0]  m_ppi, m_exp, m_key, m_main;
    logic [7:0]  m_seg [4];
    logic [7:0]  m_ram [int];

    msx_slot_top u_dut (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .req         (req),
        .rsp         (rsp)
    );

    bind msx_slot_top msx_slot_assert u_assert (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .req         (req),
        .rsp         (rsp)
    );

    initial begin
        clk_108m = 1'b0;
        forever #10 clk_108m = ~clk_108m;
    end

    always @(posedge clk_108m) cyc <= cyc + 1;

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns in test %s", TIMEOUT_NS, test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //------------------------------------------------------------
    // model decode
    //------------------------------------------------------------
    function automatic logic mapper_claims(logic [15:0] addr);
        logic [7:0] pri;
        logic [7:0] sub;
        pri = m_ppi >> (2 * addr[15:14]);
        sub = m_exp >> (2 * addr[15:14]);
        if (!m_main[0] || pri[1:0] != m_main[5:4]) return 1'b0;
        return pri[1:0] != 2'd0 || (sub[1:0] == 2'd3 && addr != 16'hffff);
    endfunction

    function automatic logic exp_claims(logic [15:0] addr);
        return addr == 16'hffff && m_ppi[7:6] == 2'd0;
    endfunction

    // 16 KB page number times page size plus offset
    function automatic int phys(logic [15:0] addr);
        return (m_seg[addr[15:14]] % (1 << `MAPPER_SEG_BITS)) * 16384 + addr[13:0];
    endfunction

    // drive one strobe, update the model and queue the expected response
    task automatic issue(input logic io, input logic wr, input logic [15:0] addr,
                         input logic [7:0] wdata);
        rsp_exp_t e;
        e.cyc     = cyc + 1;
        e.check   = 1'b1;
        e.addr    = addr;
        e.data    = `OPEN_BUS;
        req.valid = 1'b1;
        req.io    = io;
        req.write = wr;
        req.addr  = addr;
        req.wdata = wdata;
        if (io && wr) begin
            if (addr[7:0] == `PPI_PORT) m_ppi = wdata;
            if (addr[7:0] == `CFG_PORT_MAIN && m_key == `CFG_KEY) m_main = wdata;
            if (addr[7:0] == `CFG_PORT_KEY) m_key = ~wdata;
            if (addr[7:2] == `MAPPER_PORT_HI) m_seg[addr[1:0]] = wdata;
        end else if (wr) begin
            if (mapper_claims(addr)) m_ram[phys(addr)] = wdata;
            else if (exp_claims(addr)) m_exp = wdata;
        end else begin
            if (io && addr[7:0] == `CFG_PORT_KEY) e.data = m_key;
            else if (io && addr[7:0] == `CFG_PORT_MAIN) e.data = m_main;
            else if (!io && mapper_claims(addr)) begin
                e.check = m_ram.exists(phys(addr));
                if (e.check) e.data = m_ram[phys(addr)];
            end else if (!io && exp_claims(addr)) e.data = ~m_exp;
            exp_q.push_back(e);
            n_reads++;
        end
        @(posedge clk_108m);
        #2;
    endtask

    task automatic idle(input int n);
        logic [31:0] r;
        r = rand_next();
        // random fields with no strobe
        req = {1'b0, r[25:0]};
        repeat (n) begin
            @(posedge clk_108m);
            #2;
        end
    endtask

    // unwritten mapper RAM gets a byte first
    task automatic mem_read(input logic [15:0] addr);
        logic [31:0] r;
        r = rand_next();
        if (mapper_claims(addr) && !m_ram.exists(phys(addr))) begin
            issue(1'b0, 1'b1, addr, r[31:24]);
        end
        issue(1'b0, 1'b0, addr, 8'h00);
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_errs_base = err_count;
    endtask

    task automatic end_test();
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk_108m);
            #2;
        end
        assert (n_rsp == n_reads) else begin
            $display("test %s: %0d reads but %0d responses", test_name, n_reads, n_rsp);
            err_count++;
        end
        n_tests++;
        $display("test %s done, %0d errors", test_name, err_count - test_errs_base);
    endtask

    //------------------------------------------------------------
    // response checker, sampled mid-cycle
    //------------------------------------------------------------
    always @(negedge clk_108m) begin
        if (bus_reset_n && rsp.valid) begin
            n_rsp++;
            assert (exp_q.size() != 0) else begin
                $display("test %s: response in cycle %0d with no read pending", test_name, cyc);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                assert (head.cyc == cyc) else begin
                    $display("test %s: read of %h answered in cycle %0d, not in %0d",
                             test_name, head.addr, cyc, head.cyc);
                    err_count++;
                end
                if (head.check) n_checks++;
                assert (!head.check || rsp.data === head.data) else begin
                    $display("** Error test %s, read %h: expected %h, actual %h",
                             test_name, head.addr, head.data, rsp.data);
                    err_count++;
                end
            end
        end else if (bus_reset_n && exp_q.size() != 0) begin
            assert (exp_q[0].cyc > cyc) else begin
                $display("test %s: read of %h got no response", test_name, exp_q[0].addr);
                err_count++;
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [15:0] a;
        logic [1:0]  s;
        req         = '0;
        bus_reset_n = 1'b0;
        m_ppi       = 8'h00;
        m_exp       = 8'h00;
        m_key       = 8'h00;
        m_main      = `CFG_MAIN_RESET;
        for (int p = 0; p < 4; p++) m_seg[p] = 8'(3 - p);
        repeat (3) @(posedge clk_108m);
        #2;
        bus_reset_n = 1'b1;

        begin_test("reset_values");
        issue(1'b1, 1'b0, 16'h0040, 8'h00);
        issue(1'b1, 1'b0, 16'h0041, 8'h00);
        issue(1'b1, 1'b0, 16'h004c, 8'h00);
        issue(1'b0, 1'b0, 16'hffff, 8'h00);
        end_test();

        begin_test("config_key");
        // still locked here
        issue(1'b1, 1'b1, 16'h0041, 8'h30);
        issue(1'b1, 1'b0, 16'h0041, 8'h00);
        issue(1'b1, 1'b1, 16'h0040, 8'h48);
        issue(1'b1, 1'b0, 16'h0040, 8'h00);
        issue(1'b1, 1'b1, 16'h0041, 8'h21);
        issue(1'b1, 1'b0, 16'h0041, 8'h00);
        end_test();

        begin_test("slot_select");
        for (int i = 0; i < N_SLOT; i++) begin
            r = rand_next();
            issue(1'b1, 1'b1, {r[15:8], `PPI_PORT}, r[31:24]);
            r = rand_next();
            issue(1'b0, 1'b1, 16'hffff, r[31:24]);
            for (int p = 0; p < 4; p++) begin
                r = rand_next();
                mem_read({2'(p), r[29:16]});
            end
            mem_read(16'hffff);
        end
        end_test();

        begin_test("mapper");
        for (int k = 0; k < 4; k++) begin
            s = 2'(k);
            r = rand_next();
            // every page to sub-slot 3, then pages 1..3 into the mapper slot
            issue(1'b1, 1'b1, {8'h00, `PPI_PORT}, 8'h00);
            issue(1'b0, 1'b1, 16'hffff, 8'hff);
            issue(1'b1, 1'b1, {8'h00, `CFG_PORT_MAIN}, {2'b00, s, 4'h1});
            issue(1'b1, 1'b1, {8'h00, `PPI_PORT}, {s, s, s, r[31:30]});
            for (int i = 0; i < N_MAP; i++) begin
                r = rand_next();
                a = {r[17:16], 8'h00, r[23:18]};
                if (r[31:30] == 2'd0) begin
                    issue(1'b1, 1'b1, {8'h00, `MAPPER_PORT_HI, r[17:16]}, r[15:8]);
                end else if (r[31:30] == 2'd1) begin
                    issue(1'b0, 1'b1, a, r[15:8]);
                end else begin
                    mem_read(a);
                end
            end
            // in slot 0 FFFFh stays with the sub-slot register
            mem_read(16'hffff);
        end
        end_test();

        begin_test("open_bus_timing");
        // mapper off
        issue(1'b1, 1'b1, {8'h00, `CFG_PORT_MAIN}, 8'h00);
        for (int i = 0; i < N_MIX / 20; i++) begin
            r = rand_next();
            mem_read(r[31:16]);
            issue(1'b1, 1'b0, r[15:0], 8'h00);
        end
        issue(1'b1, 1'b1, {8'h00, `CFG_PORT_MAIN}, 8'h31);
        for (int i = 0; i < N_MIX; i++) begin
            r = rand_next();
            a = r[31:16];
            if (r[3]) a[7:0] = {6'b010000, r[5:4]};
            else if (r[4]) a[7:2] = `MAPPER_PORT_HI;
            if (!r[1] && !r[2]) mem_read(a);
            else issue(r[1], r[2], a, r[15:8]);
            if (r[7:6] == 2'd0) idle(int'(r[9:8]));
        end
        end_test();

        assert (u_dut.u_assert.fail_count == 0) else begin
            $display("bound assertions failed %0d times", u_dut.u_assert.fail_count);
            err_count++;
        end
        $display("%0d tests, %0d reads, %0d data checks, %0d errors",
                 n_tests, n_reads, n_checks, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hdl
hdl/msx_pkg.sv
hdl/mapper_ram.sv
hdl/slot_select.sv
hdl/config_regs.sv
hdl/mapper_ctrl.sv
hdl/read_mux.sv
hdl/msx_slot_top.sv
tests/msx_slot_assert.sv
tests/tb_msx_slot.sv

// File: Bender.yml
package:
  name: msx_slot

export_include_dirs:
  - hdl

sources:
  - hdl/msx_pkg.sv
  - hdl/mapper_ram.sv
  - hdl/slot_select.sv
  - hdl/config_regs.sv
  - hdl/mapper_ctrl.sv
  - hdl/read_mux.sv
  - hdl/msx_slot_top.sv
  - target: test
    files:
      - tests/msx_slot_assert.sv
      - tests/tb_msx_slot.sv
